// ==== dv/player_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module player_assert import player_pkg::*; (
    input wire logic Clk,
    input wire logic rst,
    input wire logic tick,
    input coord_t    x_pos,
    input coord_t    y_pos,
    input coord_t    x_spd,
    input wire logic facing_left,
    input anim_e     anim
);

    // pose only moves on the edge that ends a tick
    pose_hold: assert property (@(posedge Clk) disable iff (rst)
        !tick |=> $stable(x_pos) && $stable(y_pos) && $stable(facing_left) && $stable(anim))
        else $error("pose changed without a frame tick");

    // tick is a single cycle pulse
    tick_width: assert property (@(posedge Clk) disable iff (rst) tick |=> !tick)
        else $error("frame tick lasted two cycles");

    // run animation tracks horizontal speed
    anim_speed: assert property (@(posedge Clk) disable iff (rst)
        (anim == ANIM_RUN) == (x_spd != 0))
        else $error("animation kind disagrees with horizontal speed");

endmodule

bind motion_ctrl player_assert player_assert_i (
    .Clk         (Clk),
    .rst         (rst),
    .tick        (tick),
    .x_pos       (x_pos),
    .y_pos       (y_pos),
    .x_spd       (x_spd),
    .facing_left (facing_left),
    .anim        (anim)
);

`default_nettype wire

// ==== dv/player_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module player_tb import player_pkg::*; ();

    // reset, all frames and scan points summed, 6 cycles per frame
    localparam int FRAME_CYCLES = 6;
    localparam int TEST_CYCLES = 8 + (200 + 20 * 10 + 20 + 4 + 9) * FRAME_CYCLES + 4 * 30;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

    logic Clk, rst, frame_clk, frozen, key_left, key_right, key_jump;
    coord_t bound_x_min, bound_x_max, bound_y_min, bound_y_max;
    scan_t draw_x, draw_y;
    logic on_sprite, win;
    pixel_t pixel;
    coord_t hit_top, hit_bottom, hit_left, hit_right;

    // reference state
    int mx, my, mxs, mys, mgrav;
    bit mgnd, mface, mrun;
    logic [7:0] idle_mem [0:SPRITE_WORDS-1];
    logic [7:0] run_mem [0:SPRITE_WORDS-1];

    logic [31:0] lfsr_state;
    int errors, tests_run, tests_failed, test_start_err, cycles;
    // exit probes: just inside and just outside every edge of the door
    int exit_x [9] = '{500, 501, 555, 556, 530, 530, 530, 530, 530};
    int exit_y [9] = '{100, 100, 100, 100, 66, 67, 131, 132, 100};

    player_top player_top_i (.*);

    always #50 Clk = ~Clk;

    // run limit
    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // galois, taps for x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic compare(input string test, input string what, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("error %s %s expected %0d actual %0d", test, what, exp, act);
        end
    endtask

    task automatic begin_test();
        test_start_err = errors;
        tests_run++;
    endtask

    task automatic end_test(input string test);
        if (errors != test_start_err) begin
            tests_failed++;
            $display("%s failed", test);
        end else begin
            $display("%s passed", test);
        end
    endtask

    // one frame of the reference motion
    task automatic step_model();
        int nx, ny;
        mxs = key_left ? -2 : (key_right ? 2 : 0);
        if (mgrav == 5) begin
            mgrav = 0;
            mys = mys + 1;
        end else begin
            mgrav = mgrav + 1;
        end
        if (key_jump && mgnd) begin
            mys = -4;
            mgnd = 0;
        end
        nx = mx + mxs;
        ny = my + mys;
        if (nx < int'(bound_x_min) - 4) nx = int'(bound_x_min) - 4;
        else if (nx + 32 >= int'(bound_x_max) + 4) nx = int'(bound_x_max) - 33 + 4;
        if (ny < int'(bound_y_min)) begin
            ny = int'(bound_y_min);
            mys = 0;
        end else if (ny + 48 >= int'(bound_y_max)) begin
            ny = int'(bound_y_max) - 49;
            mys = 0;
            mgnd = 1;
        end
        mx = nx;
        my = ny;
        mrun = (mxs != 0);
        if (mxs < 0) mface = 1;
        else if (mxs > 0) mface = 0;
    endtask

    // frame clock high 3 cycles, low 3; pose is settled after the high part
    task automatic run_frame(input bit update);
        frame_clk = 1'b1;
        repeat (3) @(negedge Clk);
        if (update) step_model();
        frame_clk = 1'b0;
        repeat (3) @(negedge Clk);
    endtask

    task automatic check_hitbox(input string test);
        compare(test, "hit_top", my + 10, int'(hit_top));
        compare(test, "hit_bottom", my + 44, int'(hit_bottom));
        compare(test, "hit_left", mx + 4, int'(hit_left));
        compare(test, "hit_right", mx + 28, int'(hit_right));
    endtask

    task automatic random_keys();
        int v;
        take_bits(3, v);
        key_left = v[2];
        key_right = v[1];
        key_jump = v[0];
    endtask

    task automatic set_bounds(input int xl, input int xh, input int yl, input int yh);
        bound_x_min = coord_t'(xl);
        bound_x_max = coord_t'(xh);
        bound_y_min = coord_t'(yl);
        bound_y_max = coord_t'(yh);
    endtask

    // scan points around the sprite, pixel one cycle behind
    task automatic scan_points(input string test, input int n);
        int v, col, row, addr, exp_pix;
        bit on;
        for (int i = 0; i < n; i++) begin
            take_bits(6, v);
            draw_x = scan_t'(mx - 2 + v % 36);
            take_bits(6, v);
            draw_y = scan_t'(my - 2 + v % 52);
            col = int'(draw_x) - mx;
            row = int'(draw_y) - my;
            on = (col >= 0) && (col < 32) && (row >= 0) && (row < 48);
            if (mface) col = 31 - col;
            addr = on ? row * 32 + col : 0;
            exp_pix = mrun ? int'(run_mem[addr]) : int'(idle_mem[addr]);
            @(posedge Clk);
            compare(test, "on_sprite", int'(on), int'(on_sprite));
            @(negedge Clk);
            compare(test, "pixel", exp_pix, int'(pixel));
        end
    endtask

    initial begin
        int v, xl, yl;
        Clk = 1'b0;
        rst = 1'b1;
        frame_clk = 1'b0;
        frozen = 1'b0;
        key_left = 1'b0;
        key_right = 1'b0;
        key_jump = 1'b0;
        draw_x = '0;
        draw_y = '0;
        set_bounds(0, 639, 0, 479);
        lfsr_state = 32'd79415;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycles = 0;
        $readmemh("verilog/sprite_idle.hex", idle_mem);
        $readmemh("verilog/sprite_run.hex", run_mem);
        mx = 32;
        my = 414;
        mxs = 0;
        mys = 0;
        mgrav = 0;
        mgnd = 1;
        mface = 0;
        mrun = 0;

        begin_test();
        repeat (8) @(negedge Clk);
        check_hitbox("reset");
        compare("reset", "win", 0, int'(win));
        compare("reset", "pixel", 0, int'(pixel));
        rst = 1'b0;
        end_test("reset");

        begin_test();
        for (int f = 0; f < 200; f++) begin
            random_keys();
            run_frame(1);
            check_hitbox("random_play");
        end
        end_test("random_play");

        // small boxes push the player into walls, ceiling and floor
        begin_test();
        for (int b = 0; b < 20; b++) begin
            take_bits(8, xl);
            take_bits(7, yl);
            take_bits(5, v);
            set_bounds(xl, xl + 40 + v, yl, yl + 56 + v);
            for (int f = 0; f < 10; f++) begin
                random_keys();
                run_frame(1);
                check_hitbox("narrow_box");
            end
        end
        end_test("narrow_box");

        begin_test();
        set_bounds(0, 639, 0, 479);
        frozen = 1'b1;
        for (int f = 0; f < 20; f++) begin
            random_keys();
            run_frame(0);
            check_hitbox("frozen");
        end
        frozen = 1'b0;
        end_test("frozen");

        // run left, idle left, run right, idle right
        begin_test();
        for (int p = 0; p < 4; p++) begin
            key_left = (p == 0);
            key_right = (p == 2);
            key_jump = 1'b0;
            run_frame(1);
            check_hitbox("sprite_scan");
            scan_points("sprite_scan", 30);
        end
        end_test("sprite_scan");

        // both x walls and both y walls pinch the pose onto the probe point
        begin_test();
        key_left = 1'b0;
        key_right = 1'b0;
        for (int e = 0; e < 9; e++) begin
            set_bounds(exit_x[e] + 4, exit_x[e] + 29, exit_y[e], exit_y[e] + 49);
            run_frame(1);
            check_hitbox("exit_zone");
            compare("exit_zone", "win",
                    int'((mx + 28 > 528) && (mx + 4 < 560) && (my + 44 > 110) && (my + 10 < 142)),
                    int'(win));
        end
        end_test("exit_zone");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/player_pkg.sv
verilog/pose_if.sv
verilog/motion_ctrl.sv
verilog/exit_detect.sv
verilog/sprite_fetch.sv
verilog/player_top.sv
dv/player_assert.sv
dv/player_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the player controller testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module player_tb -f flist.f -o player_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/player_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1

// ==== verilog/exit_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module exit_detect import player_pkg::*; (
    pose_if.dst    pose,
    output coord_t hit_top,
    output coord_t hit_bottom,
    output coord_t hit_left,
    output coord_t hit_right,
    output logic   win
);

    // shrunken box, the sprite art has empty margins
    coord_t top, bottom, left, right;

    assign top = pose.y_pos + HIT_TOP;
    assign bottom = pose.y_pos + SPRITE_H - HIT_BOTTOM;
    assign left = pose.x_pos + HIT_SIDE;
    assign right = pose.x_pos + SPRITE_W - HIT_SIDE;

    assign hit_top = top;
    assign hit_bottom = bottom;
    assign hit_left = left;
    assign hit_right = right;

    // strict overlap with the exit square
    assign win = (right > EXIT_X - EXIT_RADIUS) &&
                 (left < EXIT_X + EXIT_RADIUS) &&
                 (bottom > EXIT_Y - EXIT_RADIUS) &&
                 (top < EXIT_Y + EXIT_RADIUS);

endmodule

`default_nettype wire

// ==== verilog/motion_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module motion_ctrl import player_pkg::*; (
    input  wire logic Clk,
    input  wire logic rst,
    input  wire logic frame_clk,
    input  wire logic frozen,
    input  wire logic key_left,
    input  wire logic key_right,
    input  wire logic key_jump,
    input  coord_t    bound_x_min,
    input  coord_t    bound_x_max,
    input  coord_t    bound_y_min,
    input  coord_t    bound_y_max,
    pose_if.src       pose
);

    // frame clock edge detect
    logic frame_clk_d;
    logic tick;

    // motion state
    coord_t     x_pos, y_pos;
    coord_t     x_spd, y_spd;
    logic       grounded;
    logic [2:0] grav_cnt;
    logic       facing_left;
    anim_e      anim, anim_nxt;

    // next state, only taken on a tick
    coord_t     x_nxt, y_nxt;
    coord_t     x_spd_nxt, y_spd_nxt;
    logic       grounded_nxt;
    logic [2:0] grav_nxt;
    logic       facing_nxt;

    // one Clk wide pulse after the frame clock rises
    always_ff @(posedge Clk) begin
        if (rst) begin
            frame_clk_d <= 1'b0;
            tick <= 1'b0;
        end else begin
            frame_clk_d <= frame_clk;
            tick <= frame_clk & ~frame_clk_d;
        end
    end

    always_comb begin
        // run keys, left wins over right
        if (key_left) begin
            x_spd_nxt = -RUN_SPEED;
        end else if (key_right) begin
            x_spd_nxt = RUN_SPEED;
        end else begin
            x_spd_nxt = '0;
        end

        // gravity, slowed by the frame divider
        y_spd_nxt = y_spd;
        grounded_nxt = grounded;
        grav_nxt = grav_cnt + 3'd1;
        if (grav_cnt == 3'(GRAVITY_DIV)) begin
            grav_nxt = '0;
            y_spd_nxt = y_spd + GRAVITY;
        end
        // jump only from the floor
        if (key_jump && grounded) begin
            y_spd_nxt = JUMP_V0;
            grounded_nxt = 1'b0;
        end

        x_nxt = x_pos + x_spd_nxt;
        y_nxt = y_pos + y_spd_nxt;

        // side walls, hitbox may overlap the wall by the inset
        if (x_nxt < bound_x_min - HIT_SIDE) begin
            x_nxt = bound_x_min - HIT_SIDE;
        end else if (x_nxt + SPRITE_W >= bound_x_max + HIT_SIDE) begin
            x_nxt = bound_x_max - SPRITE_W - 16'sd1 + HIT_SIDE;
        end

        // head hits the ceiling: stop rising
        if (y_nxt < bound_y_min - CEIL_PAD) begin
            y_nxt = bound_y_min - CEIL_PAD;
            y_spd_nxt = '0;
        end else if (y_nxt + SPRITE_H >= bound_y_max) begin
            // landed
            y_nxt = bound_y_max - SPRITE_H - 16'sd1;
            y_spd_nxt = '0;
            grounded_nxt = 1'b1;
        end

        // facing holds while standing still
        facing_nxt = facing_left;
        if (x_spd_nxt < 0) begin
            facing_nxt = 1'b1;
        end else if (x_spd_nxt > 0) begin
            facing_nxt = 1'b0;
        end

        // idle / run machine
        anim_nxt = anim;
        case (anim)
            ANIM_IDLE: if (x_spd_nxt != 0) anim_nxt = ANIM_RUN;
            ANIM_RUN:  if (x_spd_nxt == 0) anim_nxt = ANIM_IDLE;
            default:   anim_nxt = ANIM_IDLE;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            x_pos <= START_X;
            y_pos <= START_Y;
            x_spd <= '0;
            y_spd <= '0;
            grounded <= 1'b1;
            grav_cnt <= '0;
            facing_left <= 1'b0;
            anim <= ANIM_IDLE;
        end else if (tick && !frozen) begin
            x_pos <= x_nxt;
            y_pos <= y_nxt;
            x_spd <= x_spd_nxt;
            y_spd <= y_spd_nxt;
            grounded <= grounded_nxt;
            grav_cnt <= grav_nxt;
            facing_left <= facing_nxt;
            anim <= anim_nxt;
        end
    end

    assign pose.x_pos = x_pos;
    assign pose.y_pos = y_pos;
    assign pose.facing_left = facing_left;
    assign pose.anim = anim;

endmodule

`default_nettype wire

// ==== verilog/player_pkg.sv ====
`default_nettype none

package player_pkg;

    // signed world / screen position
    typedef logic signed [15:0] coord_t;
    // vga scan counter
    typedef logic [9:0] scan_t;
    // one colour byte from the sprite rom
    typedef logic [7:0] pixel_t;
    // index into a 32x48 sprite frame
    typedef logic [10:0] sprite_addr_t;

    // only frame 0 of each animation exists
    typedef enum logic {
        ANIM_IDLE,
        ANIM_RUN
    } anim_e;

    // sprite size and rom depth
    localparam coord_t SPRITE_W = 16'sd32;
    localparam coord_t SPRITE_H = 16'sd48;
    localparam int SPRITE_WORDS = 1536;

    // spawn point
    localparam coord_t START_X = 16'sd32;
    localparam coord_t START_Y = 16'sd414;

    // motion, pixels per frame
    localparam coord_t RUN_SPEED = 16'sd2;
    localparam coord_t JUMP_V0 = -16'sd4;
    localparam coord_t GRAVITY = 16'sd1;
    // gravity step when counter hits this, i.e. every 6th frame
    localparam int GRAVITY_DIV = 5;

    // exit door centre and half size
    localparam coord_t EXIT_X = 16'sd544;
    localparam coord_t EXIT_Y = 16'sd126;
    localparam coord_t EXIT_RADIUS = 16'sd16;

    // hitbox insets from the sprite box
    localparam coord_t HIT_TOP = 16'sd10;
    localparam coord_t HIT_BOTTOM = 16'sd4;
    localparam coord_t HIT_SIDE = 16'sd4;
    // extra room above the head at the ceiling
    localparam coord_t CEIL_PAD = 16'sd0;

endpackage

`default_nettype wire

// ==== verilog/player_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module player_top import player_pkg::*; (
    input  wire logic Clk,
    input  wire logic rst,
    input  wire logic frame_clk,
    input  wire logic frozen,
    input  wire logic key_left,
    input  wire logic key_right,
    input  wire logic key_jump,
    input  coord_t    bound_x_min,
    input  coord_t    bound_x_max,
    input  coord_t    bound_y_min,
    input  coord_t    bound_y_max,
    input  scan_t     draw_x,
    input  scan_t     draw_y,
    output logic      on_sprite,
    output pixel_t    pixel,
    output logic      win,
    output coord_t    hit_top,
    output coord_t    hit_bottom,
    output coord_t    hit_left,
    output coord_t    hit_right
);

    // registered pose shared by all three blocks
    pose_if pose_i ();

    // movement, gravity and level box
    motion_ctrl motion_ctrl_i (
        .Clk         (Clk),
        .rst         (rst),
        .frame_clk   (frame_clk),
        .frozen      (frozen),
        .key_left    (key_left),
        .key_right   (key_right),
        .key_jump    (key_jump),
        .bound_x_min (bound_x_min),
        .bound_x_max (bound_x_max),
        .bound_y_min (bound_y_min),
        .bound_y_max (bound_y_max),
        .pose        (pose_i.src)
    );

    // hitbox out to the collider, door test
    exit_detect exit_detect_i (
        .pose       (pose_i.dst),
        .hit_top    (hit_top),
        .hit_bottom (hit_bottom),
        .hit_left   (hit_left),
        .hit_right  (hit_right),
        .win        (win)
    );

    // answers the video scan
    sprite_fetch sprite_fetch_i (
        .Clk       (Clk),
        .rst       (rst),
        .pose      (pose_i.dst),
        .draw_x    (draw_x),
        .draw_y    (draw_y),
        .on_sprite (on_sprite),
        .pixel     (pixel)
    );

endmodule

`default_nettype wire

// ==== verilog/pose_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface pose_if import player_pkg::*; ();

    // top-left corner of the sprite
    coord_t x_pos;
    coord_t y_pos;
    logic   facing_left;
    anim_e  anim;

    // motion block owns the pose
    modport src (output x_pos, y_pos, facing_left, anim);
    // hitbox and sprite readers
    modport dst (input x_pos, y_pos, facing_left, anim);

endinterface

`default_nettype wire

// ==== verilog/sprite_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module sprite_fetch import player_pkg::*; (
    input  wire logic Clk,
    input  wire logic rst,
    pose_if.dst       pose,
    input  scan_t     draw_x,
    input  scan_t     draw_y,
    output logic      on_sprite,
    output pixel_t    pixel
);

    // frame 0 of each animation
    pixel_t rom_idle [SPRITE_WORDS];
    pixel_t rom_run  [SPRITE_WORDS];

    initial begin
        $readmemh("verilog/sprite_idle.hex", rom_idle);
        $readmemh("verilog/sprite_run.hex", rom_run);
    end

    // scan point relative to the sprite corner
    coord_t col, row, col_m;
    sprite_addr_t addr;

    assign col = coord_t'(draw_x) - pose.x_pos;
    assign row = coord_t'(draw_y) - pose.y_pos;

    // window test, same cycle as the scan point
    assign on_sprite = (col >= 0) && (col < SPRITE_W) &&
                       (row >= 0) && (row < SPRITE_H);

    // flip columns when looking left
    assign col_m = pose.facing_left ? SPRITE_W - 16'sd1 - col : col;

    // row-major, 32 bytes per row; park at 0 off the sprite
    assign addr = on_sprite ? sprite_addr_t'(row * SPRITE_W + col_m) : '0;

    // one cycle read latency
    always_ff @(posedge Clk) begin
        if (rst) begin
            pixel <= '0;
        end else if (pose.anim == ANIM_RUN) begin
            pixel <= rom_run[addr];
        end else begin
            pixel <= rom_idle[addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sprite_idle.hex ====
// idle frame, one sprite row per line, 32 colour bytes from column 0 to 31
00 08 10 18 20 28 30 38 40 48 50 58 60 68 70 78 80 88 90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8
01 09 11 19 21 29 31 39 41 49 51 59 61 69 71 79 81 89 91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9
02 0a 12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa
03 0b 13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb
04 0c 14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc
05 0d 15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd
06 0e 16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe
07 0f 17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff
08 10 18 20 28 30 38 40 48 50 58 60 68 70 78 80 88 90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00
09 11 19 21 29 31 39 41 49 51 59 61 69 71 79 81 89 91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01
0a 12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02
0b 13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03
0c 14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04
0d 15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05
0e 16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06
0f 17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07
10 18 20 28 30 38 40 48 50 58 60 68 70 78 80 88 90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08
11 19 21 29 31 39 41 49 51 59 61 69 71 79 81 89 91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09
12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a
13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b
14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c
15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d
16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e
17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f
18 20 28 30 38 40 48 50 58 60 68 70 78 80 88 90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10
19 21 29 31 39 41 49 51 59 61 69 71 79 81 89 91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11
1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12
1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13
1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14
1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15
1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16
1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17
20 28 30 38 40 48 50 58 60 68 70 78 80 88 90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10 18
21 29 31 39 41 49 51 59 61 69 71 79 81 89 91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11 19
22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12 1a
23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13 1b
24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14 1c
25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15 1d
26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16 1e
27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17 1f
28 30 38 40 48 50 58 60 68 70 78 80 88 90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10 18 20
29 31 39 41 49 51 59 61 69 71 79 81 89 91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11 19 21
2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12 1a 22
2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13 1b 23
2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14 1c 24
2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15 1d 25
2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16 1e 26
2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17 1f 27

// ==== verilog/sprite_run.hex ====
// run frame, one sprite row per line, 32 colour bytes from column 0 to 31
80 88 90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10 18 20 28 30 38 40 48 50 58 60 68 70 78
81 89 91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11 19 21 29 31 39 41 49 51 59 61 69 71 79
82 8a 92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a
83 8b 93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b
84 8c 94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c
85 8d 95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d
86 8e 96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e
87 8f 97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f
88 90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10 18 20 28 30 38 40 48 50 58 60 68 70 78 80
89 91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11 19 21 29 31 39 41 49 51 59 61 69 71 79 81
8a 92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82
8b 93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83
8c 94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84
8d 95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85
8e 96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86
8f 97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87
90 98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10 18 20 28 30 38 40 48 50 58 60 68 70 78 80 88
91 99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11 19 21 29 31 39 41 49 51 59 61 69 71 79 81 89
92 9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a
93 9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b
94 9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c
95 9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d
96 9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e
97 9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f
98 a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10 18 20 28 30 38 40 48 50 58 60 68 70 78 80 88 90
99 a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11 19 21 29 31 39 41 49 51 59 61 69 71 79 81 89 91
9a a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92
9b a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93
9c a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94
9d a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95
9e a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96
9f a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97
a0 a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10 18 20 28 30 38 40 48 50 58 60 68 70 78 80 88 90 98
a1 a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11 19 21 29 31 39 41 49 51 59 61 69 71 79 81 89 91 99
a2 aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92 9a
a3 ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93 9b
a4 ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94 9c
a5 ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95 9d
a6 ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96 9e
a7 af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97 9f
a8 b0 b8 c0 c8 d0 d8 e0 e8 f0 f8 00 08 10 18 20 28 30 38 40 48 50 58 60 68 70 78 80 88 90 98 a0
a9 b1 b9 c1 c9 d1 d9 e1 e9 f1 f9 01 09 11 19 21 29 31 39 41 49 51 59 61 69 71 79 81 89 91 99 a1
aa b2 ba c2 ca d2 da e2 ea f2 fa 02 0a 12 1a 22 2a 32 3a 42 4a 52 5a 62 6a 72 7a 82 8a 92 9a a2
ab b3 bb c3 cb d3 db e3 eb f3 fb 03 0b 13 1b 23 2b 33 3b 43 4b 53 5b 63 6b 73 7b 83 8b 93 9b a3
ac b4 bc c4 cc d4 dc e4 ec f4 fc 04 0c 14 1c 24 2c 34 3c 44 4c 54 5c 64 6c 74 7c 84 8c 94 9c a4
ad b5 bd c5 cd d5 dd e5 ed f5 fd 05 0d 15 1d 25 2d 35 3d 45 4d 55 5d 65 6d 75 7d 85 8d 95 9d a5
ae b6 be c6 ce d6 de e6 ee f6 fe 06 0e 16 1e 26 2e 36 3e 46 4e 56 5e 66 6e 76 7e 86 8e 96 9e a6
af b7 bf c7 cf d7 df e7 ef f7 ff 07 0f 17 1f 27 2f 37 3f 47 4f 57 5f 67 6f 77 7f 87 8f 97 9f a7
